//--- source/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~

`define CORE_XLEN       64      // RV64I integer register width.
`define CORE_INST_W     32
`define CORE_REG_AW     5       // 32 architectural registers.

// ~~~~~~~~~~~~~~~~~~~~
// Reset state
// ~~~~~~~~~~~~~~~~~~~~

`define CORE_RESET_PC   64'h0

`endif

//--- source/core_pkg.sv
`default_nettype none
`include "core_params.svh"

package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU operations
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // Operand B straight through, used by LUI.
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage payloads
    // ~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                      valid;
        logic [`CORE_XLEN-1:0]     pc;
        logic [`CORE_INST_W-1:0]   inst;
    } fetch_t;

    typedef struct packed {
        logic                      valid;
        logic [`CORE_XLEN-1:0]     pc;
        alu_op_e                   alu_op;
        logic [`CORE_REG_AW-1:0]   rd;
        logic [`CORE_REG_AW-1:0]   rs1;
        logic [`CORE_REG_AW-1:0]   rs2;
        logic [`CORE_XLEN-1:0]     rs1_val;
        logic [`CORE_XLEN-1:0]     rs2_val;
        logic [`CORE_XLEN-1:0]     imm;
        logic                      use_imm;
        logic                      word_op;    // 32-bit result, sign-extended to XLEN.
        logic                      write_rd;
        logic                      illegal;
    } decode_t;

    typedef struct packed {
        logic                      valid;
        logic [`CORE_XLEN-1:0]     pc;
        logic [`CORE_REG_AW-1:0]   rd;
        logic [`CORE_XLEN-1:0]     data;
        logic                      write_rd;
        logic                      illegal;
    } retire_t;

    typedef struct packed {
        logic                      en;
        logic [`CORE_REG_AW-1:0]   addr;
        logic [`CORE_XLEN-1:0]     data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- source/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module inst_fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CORE_INST_W-1:0]  inst,
    output logic [`CORE_XLEN-1:0]    pc,
    output core_pkg::fetch_t         if_id
);

    // No branches or stalls exist, so the PC only ever moves forward by one word.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
        end else begin
            pc <= pc + `CORE_XLEN'd4;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // IF/ID register
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else begin
            if_id.valid <= 1'b1;        // Every cycle after reset carries a real word.
            if_id.pc    <= pc;
            if_id.inst  <= inst;
        end
    end

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module inst_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pkg::fetch_t         if_id,
    output logic [`CORE_REG_AW-1:0]  rs1_addr,
    output logic [`CORE_REG_AW-1:0]  rs2_addr,
    input  logic [`CORE_XLEN-1:0]    rs1_data,
    input  logic [`CORE_XLEN-1:0]    rs2_data,
    output core_pkg::decode_t        id_ex
);

    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm_shamt;
    core_pkg::decode_t     dec;

    // Shared funct3 table of OP and OP-IMM. SUB only exists in the register form.
    function automatic core_pkg::alu_op_e funct3_op(input logic [2:0] f3, input logic alt,
                                                    input logic reg_form);
        case (f3)
            3'b000:  funct3_op = (alt && reg_form) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  funct3_op = core_pkg::ALU_SLL;
            3'b010:  funct3_op = core_pkg::ALU_SLT;
            3'b011:  funct3_op = core_pkg::ALU_SLTU;
            3'b100:  funct3_op = core_pkg::ALU_XOR;
            3'b101:  funct3_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  funct3_op = core_pkg::ALU_OR;
            default: funct3_op = core_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode    = if_id.inst[6:0];
    assign funct3    = if_id.inst[14:12];
    assign funct7    = if_id.inst[31:25];
    assign rs1_addr  = if_id.inst[19:15];
    assign rs2_addr  = if_id.inst[24:20];

    assign imm_i     = {{(`CORE_XLEN-12){if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_u     = {{(`CORE_XLEN-32){if_id.inst[31]}}, if_id.inst[31:12], 12'b0};
    assign imm_shamt = {{(`CORE_XLEN-6){1'b0}}, if_id.inst[25:20]};  // RV64 takes 6 bits.

    // ~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        dec          = '0;
        dec.valid    = if_id.valid;
        dec.pc       = if_id.pc;
        dec.rd       = if_id.inst[11:7];
        dec.rs1      = rs1_addr;
        dec.rs2      = rs2_addr;
        dec.rs1_val  = rs1_data;
        dec.rs2_val  = rs2_data;
        dec.alu_op   = funct3_op(funct3, if_id.inst[30], opcode == OPC_OP);
        dec.write_rd = 1'b1;

        case (opcode)
            OPC_LUI: begin
                dec.alu_op  = core_pkg::ALU_PASS_B;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
            end
            OPC_OP_IMM: begin
                dec.use_imm = 1'b1;
                dec.imm     = (funct3 == 3'b001 || funct3 == 3'b101) ? imm_shamt : imm_i;
                if (funct3 == 3'b001 && if_id.inst[31:26] != 6'b000000) begin
                    dec.illegal = 1'b1;
                end
                if (funct3 == 3'b101 && if_id.inst[31:26] != 6'b000000
                        && if_id.inst[31:26] != 6'b010000) begin
                    dec.illegal = 1'b1;
                end
            end
            OPC_OP: begin
                if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000
                        && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    dec.illegal = 1'b1;
                end
            end
            OPC_OP_IMM_32: begin
                dec.alu_op  = core_pkg::ALU_ADD;    // Only ADDIW is supported.
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.word_op = 1'b1;
                dec.illegal = (funct3 != 3'b000);
            end
            OPC_OP_32: begin
                dec.alu_op  = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                dec.word_op = 1'b1;
                dec.illegal = funct3 != 3'b000
                              || (funct7 != 7'b0000000 && funct7 != 7'b0100000);
            end
            default: dec.illegal = 1'b1;
        endcase

        // An unknown word retires a zero result and touches no register.
        if (dec.illegal) begin
            dec.alu_op   = core_pkg::ALU_PASS_B;
            dec.use_imm  = 1'b1;
            dec.imm      = '0;
            dec.word_op  = 1'b0;
            dec.write_rd = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= dec;
        end
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module register_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CORE_REG_AW-1:0]  rs1_addr,
    input  logic [`CORE_REG_AW-1:0]  rs2_addr,
    output logic [`CORE_XLEN-1:0]    rs1_data,
    output logic [`CORE_XLEN-1:0]    rs2_data,
    input  core_pkg::reg_write_t     wb_write
);

    localparam int NUM_REGS = 1 << `CORE_REG_AW;

    logic [`CORE_XLEN-1:0] regs [1:NUM_REGS-1];   // x0 has no storage.

    // A write landing this cycle is returned at once, so the reader two behind sees it.
    function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_AW-1:0] addr);
        if (addr == '0) begin
            read_port = '0;
        end else if (wb_write.en && wb_write.addr == addr) begin
            read_port = wb_write.data;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write.en && wb_write.addr != '0) begin
            regs[wb_write.addr] <= wb_write.data;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module alu_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pkg::decode_t        id_ex,
    output core_pkg::reg_write_t     wb_write,
    output core_pkg::retire_t        retire
);

    core_pkg::retire_t     ex_wb;
    logic                  fwd_valid;
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] rs2_fwd;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] word_a;
    logic [5:0]            shamt;
    logic [`CORE_XLEN-1:0] alu_res;
    logic [`CORE_XLEN-1:0] result;

    // ~~~~~~~~~~~~~~~~~~~~
    // Operand forwarding
    // ~~~~~~~~~~~~~~~~~~~~

    // write_rd in EX/WB is never set for x0, so x0 is never forwarded.
    assign fwd_valid = ex_wb.valid && ex_wb.write_rd && ex_wb.rd != '0;

    assign op_a    = (fwd_valid && ex_wb.rd == id_ex.rs1) ? ex_wb.data : id_ex.rs1_val;
    assign rs2_fwd = (fwd_valid && ex_wb.rd == id_ex.rs2) ? ex_wb.data : id_ex.rs2_val;
    assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;

    // Word shifts only see the low half of A and a 5-bit amount.
    assign word_a = {{(`CORE_XLEN-32){1'b0}}, op_a[31:0]};
    assign shamt  = id_ex.word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

    always_comb begin
        case (id_ex.alu_op)
            core_pkg::ALU_ADD:    alu_res = op_a + op_b;
            core_pkg::ALU_SUB:    alu_res = op_a - op_b;
            core_pkg::ALU_SLL:    alu_res = op_a << shamt;
            core_pkg::ALU_SLT:    alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU:   alu_res = {63'b0, op_a < op_b};
            core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            core_pkg::ALU_SRL:    alu_res = id_ex.word_op ? word_a >> shamt : op_a >> shamt;
            core_pkg::ALU_SRA: begin
                if (id_ex.word_op) begin
                    alu_res = $signed({{(`CORE_XLEN-32){op_a[31]}}, op_a[31:0]}) >>> shamt;
                end else begin
                    alu_res = $signed(op_a) >>> shamt;
                end
            end
            core_pkg::ALU_OR:     alu_res = op_a | op_b;
            core_pkg::ALU_AND:    alu_res = op_a & op_b;
            default:              alu_res = op_b;           // PASS_B for LUI.
        endcase
    end

    assign result = id_ex.word_op ? {{(`CORE_XLEN-32){alu_res[31]}}, alu_res[31:0]} : alu_res;

    // ~~~~~~~~~~~~~~~~~~~~
    // EX/WB register
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wb <= '0;
        end else begin
            ex_wb.valid    <= id_ex.valid;
            ex_wb.pc       <= id_ex.pc;
            ex_wb.rd       <= id_ex.rd;
            ex_wb.data     <= result;
            ex_wb.write_rd <= id_ex.write_rd && id_ex.rd != '0;  // Writes to x0 are dropped.
            ex_wb.illegal  <= id_ex.illegal;
        end
    end

    always_comb begin
        wb_write.en   = ex_wb.valid && ex_wb.write_rd && ex_wb.rd != '0;
        wb_write.addr = ex_wb.rd;
        wb_write.data = ex_wb.data;
    end

    assign retire = ex_wb;

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CORE_INST_W-1:0]  inst,
    output logic [`CORE_XLEN-1:0]    pc,
    output core_pkg::retire_t        retire
);

    core_pkg::fetch_t        if_id;
    core_pkg::decode_t       id_ex;
    core_pkg::reg_write_t    wb_write;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // Pipeline stages
    // ~~~~~~~~~~~~~~~~~~~~

    inst_fetch u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .pc       (pc),
        .if_id    (if_id)
    );

    inst_decoder u_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_id    (if_id),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .id_ex    (id_ex)
    );

    // Read in decode, written from EX/WB.
    register_file u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_write (wb_write)
    );

    alu_stage u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .wb_write (wb_write),
        .retire   (retire)
    );

endmodule

`default_nettype wire

//--- tb/core_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_props (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CORE_XLEN-1:0]  pc,
    input  core_pkg::retire_t      retire
);

    int violations = 0;

    pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> pc == $past(pc) + `CORE_XLEN'd4)
    else begin
        violations++;
        $error("pc did not advance by 4 after reset");
    end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !retire.valid)
    else begin
        violations++;
        $error("retire.valid seen while reset is asserted");
    end

    // Writes to x0 must already be dropped in EX/WB.
    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && retire.write_rd |-> retire.rd != '0)
    else begin
        violations++;
        $error("retired write targets x0");
    end

    illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && retire.illegal |-> !retire.write_rd)
    else begin
        violations++;
        $error("illegal instruction retired with a register write");
    end

endmodule

`default_nettype wire

//--- tb/core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_tb;

    localparam int PROG_LEN       = 40;
    localparam int WORDS_PER_LINE = 5;
    localparam int CLK_HALF       = 50;
    localparam int RESET_CYCLES   = 4;
    localparam int PIPE_DEPTH     = 3;
    localparam int TIMEOUT_CYCLES = PROG_LEN + PIPE_DEPTH + RESET_CYCLES + 10;
    localparam logic [`CORE_INST_W-1:0] NOP = 32'h0000_0013;   // ADDI x0, x0, 0.

    typedef struct packed {
        logic [`CORE_INST_W-1:0] inst;
        logic                    write_rd;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   data;
        logic                    illegal;
    } golden_entry_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [`CORE_INST_W-1:0] inst;
    logic [`CORE_XLEN-1:0]   pc;
    core_pkg::retire_t       retire;

    logic [`CORE_XLEN-1:0] golden_words [0:PROG_LEN*WORDS_PER_LINE-1];
    golden_entry_t         entries      [0:PROG_LEN-1];
    int                    retired_count = 0;
    int                    cycle_count   = 0;

    core_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .inst   (inst),
        .pc     (pc),
        .retire (retire)
    );

    bind core_top core_props u_props (
        .clk    (clk),
        .rst_n  (rst_n),
        .pc     (pc),
        .retire (retire)
    );

    always #CLK_HALF clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected));
    endtask

    // Each program line holds five words that make up one entry.
    task automatic load_golden();
        int base;
        $readmemh("tb/core_golden.txt", golden_words);
        for (int i = 0; i < PROG_LEN; i++) begin
            base = i * WORDS_PER_LINE;
            for (int j = 0; j < WORDS_PER_LINE; j++) begin
                assert (!$isunknown(golden_words[base + j]))
                else abort_run($sformatf("golden file has no complete entry %0d", i));
            end
            entries[i].inst     = golden_words[base][`CORE_INST_W-1:0];
            entries[i].write_rd = golden_words[base + 1][0];
            entries[i].rd       = golden_words[base + 2][`CORE_REG_AW-1:0];
            entries[i].data     = golden_words[base + 3];
            entries[i].illegal  = golden_words[base + 4][0];
        end
    endtask

    function automatic logic [`CORE_INST_W-1:0] fetch_word(input logic [`CORE_XLEN-1:0] addr);
        logic [`CORE_XLEN-1:0] index;
        index = addr >> 2;
        if (index < PROG_LEN) begin
            fetch_word = entries[int'(index)].inst;
        end else begin
            fetch_word = NOP;   // Program used up.
        end
    endfunction

    task automatic check_retire();
        golden_entry_t         expected;
        logic [`CORE_XLEN-1:0] expected_pc;
        expected_pc = `CORE_RESET_PC + `CORE_XLEN'(retired_count * 4);
        assert (retire.pc == expected_pc)
        else abort_run($sformatf("retire out of program order: pc 0x%h arrived, 0x%h was due",
                                 retire.pc, expected_pc));
        expected = entries[retired_count];
        assert (retire.write_rd == expected.write_rd)
        else report_mismatch("retire.write_rd", retire.write_rd, expected.write_rd);
        assert (retire.rd == expected.rd)
        else report_mismatch("retire.rd", retire.rd, expected.rd);
        assert (retire.data == expected.data)
        else report_mismatch("retire.data", retire.data, expected.data);
        assert (retire.illegal == expected.illegal)
        else report_mismatch("retire.illegal", retire.illegal, expected.illegal);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n = 1'b1;
        inst  = NOP;
        load_golden();
        #1 rst_n = 1'b0;        // A clean falling edge clears the flops before the first clock.
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    // Instruction memory answers the pc that fetch shows after the edge.
    always @(posedge clk) begin
        #1 inst = fetch_word(pc);
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Checking
    // ~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (rst_n && retire.valid) begin
            check_retire();
            retired_count++;
            if (retired_count == PROG_LEN) begin
                if (uut.u_props.violations == 0) begin
                    $display("Test passed");
                    $finish;
                end else begin
                    abort_run($sformatf("%0d property checks failed during the run",
                                        uut.u_props.violations));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < TIMEOUT_CYCLES)
        else abort_run("timeout: not all instructions retired");
    end

endmodule

`default_nettype wire

//--- tb/core_golden.txt
// Columns: instruction word, write flag, rd, result data, illegal flag.
// One instruction per line in program order from pc 0; the line index is pc/4.
00500093 1 01 0000000000000005 0
FFD00113 1 02 FFFFFFFFFFFFFFFD 0
123451B7 1 03 0000000012345000 0
80000237 1 04 FFFFFFFF80000000 0
7FF08293 1 05 0000000000000804 0
80028313 1 06 0000000000000004 0
FFE12393 1 07 0000000000000001 0
FFF0B413 1 08 0000000000000001 0
FFF14493 1 09 0000000000000002 0
0FF1E513 1 0A 00000000123450FF 0
7F057593 1 0B 00000000000000F0 0
02809613 1 0C 0000050000000000 0
02425693 1 0D 000000000FFFFFFF 0
40425713 1 0E FFFFFFFFF8000000 0
002087B3 1 0F 0000000000000002 0
40178833 1 10 FFFFFFFFFFFFFFFD 0
003228B3 1 11 0000000000000001 0
03F41913 1 12 8000000000000000 0
001929B3 1 13 0000000000000001 0
00193A33 1 14 0000000000000000 0
40D95AB3 1 15 FFFFFFFFFFFFFFFF 0
00D95B33 1 16 0000000000000001 0
00909BB3 1 17 0000000000000014 0
015BCC33 1 18 FFFFFFFFFFFFFFEB 0
017B6CB3 1 19 0000000000000015 0
019C7D33 1 1A 0000000000000001 0
7FFFFDB7 1 1B 000000007FFFF000 0
FFF20E1B 1 1C 000000007FFFFFFF 0
01BD8EBB 1 1D FFFFFFFFFFFFE000 0
41CE8F3B 1 1E 000000007FFFE001 0
00708013 0 00 000000000000000C 0
00100FB3 1 1F 0000000000000005 0
ABCDE037 0 00 FFFFFFFFABCDE000 0
000000B3 1 01 0000000000000000 0
00003283 0 05 0000000000000000 1
00028333 1 06 0000000000000804 0
022083B3 0 07 0000000000000000 1
FFFFFFFF 0 1F 0000000000000000 1
00038413 1 08 0000000000000001 0
01EF84B3 1 09 000000007FFFE006 0

//--- project.f
+incdir+source
source/core_pkg.sv
source/inst_fetch.sv
source/inst_decoder.sv
source/register_file.sv
source/alu_stage.sv
source/core_top.sv
tb/core_props.sv
tb/core_tb.sv

//--- Bender.yml
package:
  name: rv64i_pipe_core

export_include_dirs:
  - source

sources:
  # RTL in compile order.
  - files:
      - source/core_pkg.sv
      - source/inst_fetch.sv
      - source/inst_decoder.sv
      - source/register_file.sv
      - source/alu_stage.sv
      - source/core_top.sv

  # Testbench, top module core_tb.
  - target: test
    include_dirs:
      - source
    files:
      - tb/core_props.sv
      - tb/core_tb.sv
